// ==== ft64FetchFront.f ====
hdl/ft64Pkg.sv
hdl/ft64IExpander.sv
hdl/ft64ParcelQueue.sv
hdl/ft64InstrAligner.sv
hdl/ft64FetchFront.sv
sim/ft64FetchFrontTb.sv

// ==== Makefile ====
# Verilator build and run for the fetch front end testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= ft64FetchFrontTb
FILELIST  ?= ft64FetchFront.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Result: pass" || \
		(echo "Result: fail, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== sim/ft64FetchFrontTb.sv ====
`timescale 1ns/1ps
// ==============================
// Testbench for the fetch front end. Streams a table of
// parcels through the DUT and checks every instruction
// ==============================
module ft64FetchFrontTb;

	localparam int Depth = 16;
	localparam ft64Pkg::addrT ResetPc = 32'h0000_0100;
	localparam ft64Pkg::addrT RedirectPc = 32'h0000_2040;	// Aligned to 8
	localparam int NumEntries = 13;
	localparam int NumWords = 5;			// 20 parcels in the table
	localparam int HalfPeriod = 2;			// 4 ns clock
	localparam int WatchdogCycles = NumEntries * 40;

	typedef struct packed {
		ft64Pkg::parcelT [2:0] parcels;
		ft64Pkg::instrT instr;
		logic compressed;
		logic [1:0] len;		// Parcels, 1 to 3
	} entryT;

	logic clk = 1'b0;
	logic arstN;
	logic fetchValid;
	ft64Pkg::fetchWordT fetchWord;
	logic fetchReady;
	logic redirectValid;
	ft64Pkg::addrT redirectPc;
	logic instrValid;
	ft64Pkg::fetchedInstrT instrOut;
	logic overflow;

	entryT tbl [NumEntries];
	ft64Pkg::fetchWordT words [NumWords];
	ft64Pkg::parcelT stream [$];
	ft64Pkg::fetchedInstrT expQ [$];		// Expected output in order
	ft64Pkg::fetchedInstrT expCur;
	logic [15:0] lfsr = 16'd91;
	int checkCount = 0;
	int errorCount = 0;
	int gotCount = 0;
	int testErrs;

	always #HalfPeriod clk = ~clk;

	ft64FetchFront #(
		.Depth(Depth),
		.ResetPc(ResetPc)
	) u_ft64FetchFront (
		.clk(clk),
		.arstN(arstN),
		.fetchValid(fetchValid),
		.fetchWord(fetchWord),
		.fetchReady(fetchReady),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.instrValid(instrValid),
		.instrOut(instrOut),
		.overflow(overflow)
	);

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Two LFSR bits give an idle gap of 0 to 3 cycles
	task automatic drawGap(output int gap);
		gap = 0;
		for (int b = 0; b < 2; b++)
		begin
			lfsr = lfsrNext(lfsr);
			gap = (gap << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic setEntry(input int i, input int len, input ft64Pkg::parcelT p0,
		input ft64Pkg::parcelT p1, input ft64Pkg::parcelT p2, input ft64Pkg::instrT ins);
		tbl[i].parcels = {p2, p1, p0};
		tbl[i].instr = ins;
		tbl[i].compressed = (len == 1);
		tbl[i].len = 2'(len);
	endtask

	// ==============================
	// Stimulus and expected values
	// ==============================
	task automatic buildTable();
		setEntry(0, 1, 16'h0125, 16'h0, 16'h0, 48'h0000_000C_A584);	// ADDI r5,r5,3
		setEntry(1, 2, 16'h1284, 16'hABCD, 16'h0, 48'h0000_ABCD_1284);
		setEntry(2, 1, 16'h0243, 16'h0, 16'h0, 48'h0000_4B80_8382);	// MOV r4 from r3
		setEntry(3, 3, 16'h34C5, 16'h5678, 16'h9ABC, 48'h9ABC_5678_34C5);
		setEntry(4, 1, 16'h413A, 16'h0, 16'h0, 48'h0000_15AC_8482);	// SUB r4,r4,r11
		setEntry(5, 2, 16'h2A96, 16'h1357, 16'h0, 48'h0000_1357_2A96);
		setEntry(6, 1, 16'h4E3F, 16'h0, 16'h0, 48'h0000_29CA_9482);	// XOR r20,r20,r18
		setEntry(7, 3, 16'h7FC2, 16'h2468, 16'hACE0, 48'hACE0_2468_7FC2);	// Crosses words
		setEntry(8, 1, 16'h5000, 16'h0, 16'h0, 48'h0000_0000_009C);	// Undefined, NOP
		setEntry(9, 2, 16'h0E8B, 16'hF00D, 16'h0, 48'h0000_F00D_0E8B);	// Crosses words
		setEntry(10, 1, 16'h1000, 16'h0, 16'h0, 48'h0000_0080_2080);	// BRK cause 1
		setEntry(11, 1, 16'h5061, 16'h0, 16'h0, 48'h0000_0020_3FA3);	// LW r1,8(sp)
		setEntry(12, 1, 16'h0F3F, 16'h0, 16'h0, 48'h0000_FF63_FF84);	// SP adjust by -8
	endtask

	task automatic packWords();
		for (int i = 0; i < NumEntries; i++)
			for (int k = 0; k < int'(tbl[i].len); k++)
				stream.push_back(tbl[i].parcels[k]);
		for (int w = 0; w < NumWords; w++)
			for (int k = 0; k < 4; k++)
				words[w].parcel[k] = stream[w * 4 + k];	// Parcel 0 lowest
	endtask

	// PCs follow the table lengths from a start address
	task automatic queueExpected(input int first, input int last, input ft64Pkg::addrT startPc);
		ft64Pkg::fetchedInstrT e;
		ft64Pkg::addrT pc;
		pc = startPc;
		for (int i = first; i <= last; i++)
		begin
			e.instr = tbl[i].instr;
			e.pc = pc;
			e.compressed = tbl[i].compressed;
			expQ.push_back(e);
			pc = pc + ft64Pkg::addrT'(2 * int'(tbl[i].len));
		end
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic sendWord(input ft64Pkg::fetchWordT w);
		while (!fetchReady)
			@(negedge clk);
		fetchValid = 1'b1;
		fetchWord = w;
		@(negedge clk);
		fetchValid = 1'b0;
	endtask

	task automatic sendWords(input int first, input int last);
		int gap;
		for (int w = first; w <= last; w++)
		begin
			drawGap(gap);
			repeat (gap) @(negedge clk);
			sendWord(words[w]);
		end
	endtask

	task automatic waitFor(input int n);
		while (gotCount < n)
			@(negedge clk);
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		$display("Test %s: done, %0d errors", name, errorCount - errsBefore);
	endtask

	// ==============================
	// Output monitor
	// ==============================
	always @(negedge clk)
	begin
		if (arstN && instrValid)
		begin
			if (expQ.size() == 0)
			begin
				errorCount++;
				$display("Unexpected instruction at %0t ns with PC %h, none was expected",
					$time, instrOut.pc);
			end
			else
			begin
				expCur = expQ.pop_front();
				compare(64'(instrOut.instr), 64'(expCur.instr),
					$sformatf("instruction %0d value", gotCount));
				compare(64'(instrOut.pc), 64'(expCur.pc), $sformatf("instruction %0d PC", gotCount));
				compare(64'(instrOut.compressed), 64'(expCur.compressed),
					$sformatf("instruction %0d compressed flag", gotCount));
			end
			gotCount++;
		end
	end

	initial
	begin
		#(WatchdogCycles * 2 * HalfPeriod);
		$display("Timeout: the run did not finish within %0d clock cycles", WatchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		arstN = 1'b0;
		fetchValid = 1'b0;
		fetchWord = '0;
		redirectValid = 1'b0;
		redirectPc = '0;
		buildTable();
		packWords();
		repeat (16) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);

		testErrs = errorCount;
		compare(64'(instrValid), 64'd0, "instrValid after reset");
		compare(64'(overflow), 64'd0, "overflow after reset");
		compare(64'(fetchReady), 64'd1, "fetchReady after reset");
		reportTest("reset state", testErrs);

		testErrs = errorCount;
		queueExpected(0, NumEntries - 1, ResetPc);
		sendWords(0, NumWords - 1);
		waitFor(NumEntries);
		compare(64'(overflow), 64'd0, "overflow after random gaps");
		reportTest("table stream with random gaps", testErrs);

		testErrs = errorCount;
		repeat (4) @(negedge clk);
		queueExpected(0, 4, RedirectPc);
		fetchValid = 1'b1;
		fetchWord = words[2];		// Queued, then flushed
		@(negedge clk);
		fetchWord = words[3];		// Dropped with the redirect
		redirectValid = 1'b1;
		redirectPc = RedirectPc;
		@(negedge clk);
		fetchValid = 1'b0;
		redirectValid = 1'b0;
		sendWords(0, 1);
		waitFor(NumEntries + 5);
		repeat (8) @(negedge clk);
		compare(64'(gotCount), 64'(NumEntries + 5), "instructions delivered after redirect");
		compare(64'(overflow), 64'd0, "overflow after redirect");
		compare(64'(fetchReady), 64'd1, "fetchReady at end");
		reportTest("redirect", testErrs);

		$display("Checks: %0d, errors: %0d, instructions: %0d", checkCount, errorCount, gotCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== hdl/ft64FetchFront.sv ====
`timescale 1ns/1ps
// ==============================
// Fetch front end top level, queue to aligner
// ==============================
module ft64FetchFront
#(
	parameter int Depth = 16,
	parameter ft64Pkg::addrT ResetPc = '0
)
(
	input logic clk,
	input logic arstN,
	input logic fetchValid,
	input ft64Pkg::fetchWordT fetchWord,
	output logic fetchReady,
	input logic redirectValid,
	input ft64Pkg::addrT redirectPc,
	output logic instrValid,
	output ft64Pkg::fetchedInstrT instrOut,
	output logic overflow
);

	ft64Pkg::parcelT [2:0] headParcels;
	logic [$clog2(Depth):0] count;
	logic [1:0] headCount;
	logic [1:0] popCount;
	ft64Pkg::instrT expanded;

	// Aligner only cares about up to three parcels
	assign headCount = (count > 3) ? 2'd3 : count[1:0];

	ft64ParcelQueue #(
		.Depth(Depth)
	) u_ft64ParcelQueue (
		.clk(clk),
		.arstN(arstN),
		.wrEn(fetchValid),
		.wrWord(fetchWord),
		.popCount(popCount),
		.flush(redirectValid),
		.headParcels(headParcels),
		.count(count),
		.ready(fetchReady),
		.overflow(overflow)
	);

	ft64IExpander u_ft64IExpander (
		.cinstr(headParcels[0]),
		.expand(expanded)
	);

	ft64InstrAligner #(
		.ResetPc(ResetPc)
	) u_ft64InstrAligner (
		.clk(clk),
		.arstN(arstN),
		.headParcels(headParcels),
		.count(headCount),
		.expanded(expanded),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.popCount(popCount),
		.instrValid(instrValid),
		.instrOut(instrOut)
	);

endmodule

// ==== hdl/ft64InstrAligner.sv ====
`timescale 1ns/1ps
// ==============================
// Takes the head instruction off the parcel queue,
// picks its final form and registers it with its PC
// ==============================
module ft64InstrAligner
#(
	parameter ft64Pkg::addrT ResetPc = '0
)
(
	input logic clk,
	input logic arstN,
	input ft64Pkg::parcelT [2:0] headParcels,
	input logic [1:0] count,
	input ft64Pkg::instrT expanded,
	input logic redirectValid,
	input ft64Pkg::addrT redirectPc,
	output logic [1:0] popCount,
	output logic instrValid,
	output ft64Pkg::fetchedInstrT instrOut
);

	ft64Pkg::addrT pc;
	logic [1:0] lenCode;
	logic [1:0] need;		// Parcels in the head instruction
	logic fire;
	ft64Pkg::instrT assembled;

	// Bit 7 clear means compressed whatever bit 6 holds
	assign lenCode = headParcels[0][ft64Pkg::fieldLen + 1] ?
		headParcels[0][ft64Pkg::fieldLen +: 2] : ft64Pkg::lenCompressed;

	always_comb
	begin
		case (lenCode)
		ft64Pkg::len32:
			begin
				need = 2'd2;
				assembled = {16'h0000, headParcels[1], headParcels[0]};	// Zero extended
			end
		ft64Pkg::len48:
			begin
				need = 2'd3;
				assembled = {headParcels[2], headParcels[1], headParcels[0]};
			end
		default:
			begin
				need = 2'd1;
				assembled = expanded;
			end
		endcase
	end

	// Empty check first so an unwritten head is never looked at
	assign fire = (count != 2'd0) && (count >= need) && !redirectValid;
	assign popCount = fire ? need : 2'd0;

	// ==============================
	// PC and output register
	// ==============================
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			pc <= ResetPc;
			instrValid <= 1'b0;
		end
		else
		begin
			instrValid <= fire;
			if (redirectValid)
				pc <= redirectPc;
			else if (fire)
				pc <= pc + ft64Pkg::addrT'({need, 1'b0});	// 2, 4 or 6 bytes
		end
	end

	always_ff @(posedge clk)
	begin
		if (fire)
		begin
			instrOut.instr <= assembled;
			instrOut.pc <= pc;
			instrOut.compressed <= (lenCode == ft64Pkg::lenCompressed);
		end
	end

endmodule

// ==== hdl/ft64ParcelQueue.sv ====
`timescale 1ns/1ps
// ==============================
// Circular parcel queue, four parcels in per write,
// up to three out per cycle, cleared by flush
// ==============================
module ft64ParcelQueue
#(
	parameter int Depth = 16
)
(
	input logic clk,
	input logic arstN,
	input logic wrEn,
	input ft64Pkg::fetchWordT wrWord,
	input logic [1:0] popCount,
	input logic flush,
	output ft64Pkg::parcelT [2:0] headParcels,
	output logic [$clog2(Depth):0] count,
	output logic ready,
	output logic overflow
);

	localparam int PtrW = $clog2(Depth);
	localparam int CntW = PtrW + 1;
	localparam logic [CntW-1:0] ReadyLimit = CntW'(Depth - 4);	// Room for one word

	ft64Pkg::parcelT mem [Depth];
	logic [PtrW-1:0] rdPtr;
	logic [PtrW-1:0] wrPtr;
	logic wrOk;

	assign ready = (count <= ReadyLimit);
	assign wrOk = wrEn && ready && !flush;

	// Oldest three parcels
	always_comb
	begin
		for (int i = 0; i < 3; i++)
			headParcels[i] = mem[rdPtr + PtrW'(i)];
	end

	always_ff @(posedge clk)
	begin
		if (wrOk)
			for (int i = 0; i < 4; i++)
				mem[wrPtr + PtrW'(i)] <= wrWord.parcel[i];
	end

	// ==============================
	// Pointers, count, overflow
	// ==============================
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end
		else if (flush)
		begin
			rdPtr <= '0;		// Redirect empties the queue
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			rdPtr <= rdPtr + PtrW'(popCount);
			if (wrOk)
				wrPtr <= wrPtr + PtrW'(4);
			count <= count + (wrOk ? CntW'(4) : CntW'(0)) - CntW'(popCount);
			if (wrEn && !ready)
				overflow <= 1'b1;	// Sticky until reset
		end
	end

endmodule

// ==== hdl/ft64IExpander.sv ====
`timescale 1ns/1ps
// ==============================
// Expands a compressed parcel into the full 48 bit
// format in the same cycle; unknown codes give a NOP
// ==============================
module ft64IExpander
(
	input ft64Pkg::parcelT cinstr,
	output ft64Pkg::instrT expand
);

	localparam logic [5:0] fnShiftImm = 6'h0F;	// Shift by immediate 0-31
	localparam logic [2:0] shSll = 3'd0;
	localparam logic [2:0] shSrl = 3'd1;
	localparam logic [2:0] shSra = 3'd3;
	localparam logic [2:0] szWord = 3'b011;
	localparam logic [2:0] szMove = 3'd7;		// Current set to current set
	localparam logic [2:0] condEq = 3'd0;
	localparam logic [2:0] condNe = 3'd1;
	localparam ft64Pkg::regT regSp = 5'd31;
	localparam ft64Pkg::regT regFp = 5'd30;
	localparam ft64Pkg::regT regLk = 5'd29;

	// Register map for three bit register codes
	function automatic ft64Pkg::regT fnRp(input logic [2:0] rg);
		ft64Pkg::regT r;
		case (rg)
		3'd0: r = 5'd1;		// Return value
		3'd1: r = 5'd3;		// Temporaries
		3'd2: r = 5'd4;
		3'd3: r = 5'd11;	// Register variables
		3'd4: r = 5'd12;
		3'd5: r = 5'd18;	// Arguments
		3'd6: r = 5'd19;
		default: r = 5'd20;
		endcase
		return r;
	endfunction

	function automatic ft64Pkg::instrT baseForm(input logic [5:0] op);
		ft64Pkg::instrT r;
		r = '0;
		r[ft64Pkg::fieldLen +: 2] = ft64Pkg::len32;
		r[ft64Pkg::fieldOp +: 6] = op;
		return r;
	endfunction

	// Immediate split around the size bit
	function automatic ft64Pkg::instrT immForm(input logic [5:0] op, input ft64Pkg::regT rt,
		input ft64Pkg::regT ra, input logic [12:0] imm);
		ft64Pkg::instrT r;
		r = baseForm(op);
		r[ft64Pkg::fieldImmHi +: 8] = imm[12:5];
		r[ft64Pkg::fieldRb +: 5] = imm[4:0];
		r[ft64Pkg::fieldRt +: 5] = rt;
		r[ft64Pkg::fieldRa +: 5] = ra;
		return r;
	endfunction

	// Stores move the low immediate into the target slot
	function automatic ft64Pkg::instrT storeForm(input logic [5:0] op, input ft64Pkg::regT rs,
		input ft64Pkg::regT ra, input logic [12:0] imm, input logic wide);
		ft64Pkg::instrT r;
		r = baseForm(op);
		r[ft64Pkg::fieldImmHi +: 8] = imm[12:5];
		r[ft64Pkg::fieldSz] = wide;
		r[ft64Pkg::fieldRb +: 5] = rs;
		r[ft64Pkg::fieldRt +: 5] = imm[4:0];
		r[ft64Pkg::fieldRa +: 5] = ra;
		return r;
	endfunction

	function automatic ft64Pkg::instrT r2Form(input logic [5:0] fn, input logic [2:0] sz,
		input ft64Pkg::regT rb, input ft64Pkg::regT rt, input ft64Pkg::regT ra);
		ft64Pkg::instrT r;
		r = baseForm(ft64Pkg::opR2);
		r[ft64Pkg::fieldFn +: 6] = fn;
		r[ft64Pkg::fieldSz +: 3] = sz;
		r[ft64Pkg::fieldRb +: 5] = rb;
		r[ft64Pkg::fieldRt +: 5] = rt;
		r[ft64Pkg::fieldRa +: 5] = ra;
		return r;
	endfunction

	// Branch against r0, displacement in two pieces
	function automatic ft64Pkg::instrT bccForm(input logic [2:0] cond, input ft64Pkg::regT ra,
		input logic [10:0] disp);
		ft64Pkg::instrT r;
		r = baseForm(ft64Pkg::opBcc);
		r[ft64Pkg::fieldSz +: 9] = disp[10:2];
		r[ft64Pkg::fieldRt + 3 +: 2] = disp[1:0];
		r[ft64Pkg::fieldRt +: 3] = cond;
		r[ft64Pkg::fieldRa +: 5] = ra;
		return r;
	endfunction

	ft64Pkg::regT rd;		// Full destination
	ft64Pkg::regT rs;		// Full source or five bit immediate
	ft64Pkg::regT rpd;		// Mapped destination or base
	ft64Pkg::regT rpb;		// Mapped R2 source
	ft64Pkg::regT rpm;		// Mapped load target, store source
	logic [12:0] simm;

	assign rd = cinstr[4:0];
	assign rs = {cinstr[11:8], cinstr[5]};
	assign rpd = fnRp(cinstr[2:0]);
	assign rpb = fnRp({cinstr[9:8], cinstr[3]});
	assign rpm = fnRp({cinstr[9:8], cinstr[5]});
	assign simm = {{8{cinstr[11]}}, cinstr[11:8], cinstr[5]};

	// ==============================
	// Decode on bits 15:12 and 6
	// ==============================
	always_comb
	begin
		expand = baseForm(ft64Pkg::opNop);
		casez ({cinstr[15:12], cinstr[6]})
		5'b0000_0:
			if (rd == regSp)	// SP adjust scaled by 8
				expand = immForm(ft64Pkg::opAddi, regSp, regSp, {simm[9:0], 3'b000});
			else
				expand = immForm(ft64Pkg::opAddi, rd, rd, simm);
		5'b0001_0:
			if (rd == 5'd0)
			begin
				expand = baseForm(ft64Pkg::opBrk);
				expand[ft64Pkg::fieldRa +: 8] = {3'd1, rs};	// Cause code
				expand[ft64Pkg::fieldSz +: 3] = 3'd1;
			end
			else
				expand = immForm(ft64Pkg::opAddi, rd, 5'd0, simm);	// LDI
		5'b0010_0:
			if (rd == 5'd0)	// RET, pops the stack by 8 per unit
				expand = immForm(ft64Pkg::opRet, regSp, regSp, {5'd0, rs, 3'b000});
			else
				expand = immForm(ft64Pkg::opAndi, rd, rd, simm);
		5'b0011_0:
			expand = r2Form(fnShiftImm, shSll, rs, rd, rd);
		5'b0100_0:
			case (cinstr[5:4])
			2'd0: expand = r2Form(fnShiftImm, shSrl, {cinstr[11:8], cinstr[3]}, rpd, rpd);
			2'd1: expand = r2Form(fnShiftImm, shSra, {cinstr[11:8], cinstr[3]}, rpd, rpd);
			2'd2: expand = immForm(ft64Pkg::opOri, rpd, rpd,
				{{8{cinstr[11]}}, cinstr[11:8], cinstr[3]});
			default:
				case (cinstr[11:10])
				2'd0: expand = r2Form(ft64Pkg::fnSub, szWord, rpb, rpd, rpd);
				2'd1: expand = r2Form(ft64Pkg::fnAnd, szWord, rpb, rpd, rpd);
				2'd2: expand = r2Form(ft64Pkg::fnOr, szWord, rpb, rpd, rpd);
				default: expand = r2Form(ft64Pkg::fnXor, szWord, rpb, rpd, rpd);
				endcase
			endcase
		5'b0110_0:
			begin
				expand = baseForm(ft64Pkg::opFmt);
				expand[31:16] = cinstr;		// Whole parcel carried along
			end
		5'b0111_0:	// Unconditional, r0 equals r0
			expand = bccForm(condEq, 5'd0, {cinstr[11], cinstr[11:8], cinstr[5:0]});
		5'b10??_0:
			expand = bccForm(condEq, rd,
				{{4{cinstr[13]}}, cinstr[13:9], cinstr[8], cinstr[5]});
		5'b11??_0:
			expand = bccForm(condNe, rd,
				{{4{cinstr[13]}}, cinstr[13:9], cinstr[8], cinstr[5]});
		5'b0000_1:
			expand = r2Form(ft64Pkg::fnMov, szMove, 5'd0, rs, rd);
		5'b0001_1:
			expand = r2Form(ft64Pkg::fnAdd, szWord, rs, rd, rd);
		5'b0010_1:
			expand = immForm(ft64Pkg::opJal, rs, rd, 13'd0);	// JALR
		5'b0011_1:
			if (rs == 5'd0)
			begin
				expand = storeForm(ft64Pkg::opMsx, rd, regSp, 13'd0, 1'b0);	// PUSH
				expand[ft64Pkg::fieldRt +: 5] = regSp;
				expand[31:28] = 4'hC;
			end
			else
				expand = r2Form(ft64Pkg::fnMov, szMove, 5'd0, rd, regLk);	// Link to reg
		// SP and FP relative, word forms scaled by 8
		5'b0100_1: expand = immForm(ft64Pkg::opLh, rd, regSp, {simm[10:0], 2'b00});
		5'b0101_1: expand = immForm(ft64Pkg::opLw, rd, regSp, {simm[9:0], 3'b000});
		5'b0110_1: expand = immForm(ft64Pkg::opLh, rd, regFp, {simm[10:0], 2'b00});
		5'b0111_1: expand = immForm(ft64Pkg::opLw, rd, regFp, {simm[9:0], 3'b000});
		5'b1000_1: expand = storeForm(ft64Pkg::opSh, rd, regSp, {simm[10:0], 2'b00}, 1'b0);
		5'b1001_1: expand = storeForm(ft64Pkg::opSh, rd, regSp, {simm[9:0], 3'b000}, 1'b1);
		5'b1010_1: expand = storeForm(ft64Pkg::opSh, rd, regFp, {simm[10:0], 2'b00}, 1'b0);
		5'b1011_1: expand = storeForm(ft64Pkg::opSh, rd, regFp, {simm[9:0], 3'b000}, 1'b1);
		// Mapped base register
		5'b1100_1:
			expand = immForm(ft64Pkg::opLh, rpm, rpd,
				{{7{cinstr[11]}}, cinstr[11:10], cinstr[4:3], 2'b00});
		5'b1101_1:
			expand = immForm(ft64Pkg::opLw, rpm, rpd,
				{{6{cinstr[11]}}, cinstr[11:10], cinstr[4:3], 3'b000});
		5'b1110_1:
			expand = storeForm(ft64Pkg::opSh, rpm, rpd,
				{{7{cinstr[11]}}, cinstr[11:10], cinstr[4:3], 2'b00}, 1'b0);
		5'b1111_1:
			expand = storeForm(ft64Pkg::opSh, rpm, rpd,
				{{6{cinstr[11]}}, cinstr[11:10], cinstr[4:3], 3'b000}, 1'b1);
		default:
			expand = baseForm(ft64Pkg::opNop);
		endcase
	end

endmodule

// ==== hdl/ft64Pkg.sv ====
// ==============================
// Shared types, field positions and opcodes
// for the fetch front end, referenced by scope
// ==============================
package ft64Pkg;

	typedef logic [15:0] parcelT;		// One instruction parcel
	typedef logic [47:0] instrT;		// Full format instruction
	typedef logic [31:0] addrT;		// Byte address
	typedef logic [4:0] regT;		// Register number

	typedef struct packed {
		parcelT [3:0] parcel;		// Parcel 0 in the low bits
	} fetchWordT;

	typedef struct packed {
		instrT instr;
		addrT pc;
		logic compressed;		// Came from a 16 bit parcel
	} fetchedInstrT;

	// ==============================
	// Field positions, full format
	// ==============================
	localparam int fieldOp = 0;		// Major opcode, 6 bits
	localparam int fieldLen = 6;		// Length code, 2 bits
	localparam int fieldRa = 8;		// Source A
	localparam int fieldRt = 13;		// Target
	localparam int fieldRb = 18;		// Source B or low immediate
	localparam int fieldSz = 23;		// Size or store width
	localparam int fieldImmHi = 24;		// Upper immediate, 8 bits
	localparam int fieldFn = 26;		// R2 function

	// Length codes in parcel bits 7:6
	localparam logic [1:0] lenCompressed = 2'b00;
	localparam logic [1:0] len32 = 2'b10;
	localparam logic [1:0] len48 = 2'b11;

	// ==============================
	// Opcodes emitted by the expander
	// ==============================
	localparam logic [5:0] opBrk = 6'h00;
	localparam logic [5:0] opR2 = 6'h02;
	localparam logic [5:0] opAddi = 6'h04;
	localparam logic [5:0] opAndi = 6'h08;
	localparam logic [5:0] opOri = 6'h09;
	localparam logic [5:0] opFmt = 6'h0F;
	localparam logic [5:0] opJal = 6'h18;
	localparam logic [5:0] opNop = 6'h1C;
	localparam logic [5:0] opLh = 6'h20;
	localparam logic [5:0] opSh = 6'h21;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opRet = 6'h29;
	localparam logic [5:0] opMsx = 6'h2F;
	localparam logic [5:0] opBcc = 6'h38;

	// R2 function codes
	localparam logic [5:0] fnAdd = 6'h04;
	localparam logic [5:0] fnSub = 6'h05;
	localparam logic [5:0] fnAnd = 6'h08;
	localparam logic [5:0] fnOr = 6'h09;
	localparam logic [5:0] fnXor = 6'h0A;
	localparam logic [5:0] fnMov = 6'h12;

endpackage
